/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := dllp_generator_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+include
hdl/dllp_pkg.sv
hdl/fc_init_sequencer.sv
hdl/active_dllp_scheduler.sv
hdl/dllp_tx_arbiter.sv
hdl/dllp_framer.sv
hdl/dllp_generator_top.sv
tb/tb_clock_gen.sv
tb/dllp_generator_tb.sv

/* hdl/active_dllp_scheduler.sv */
`timescale 1ns/1ps

module active_dllp_scheduler #(
    parameter int RESEND_INTERVAL = 1024
) (
    input  logic                  sclk,
    input  logic                  rst_i,
    input  dllp_pkg::link_state_e link_state_i,
    input  dllp_pkg::fc_credit_t  cc_p_h_i,
    input  dllp_pkg::fc_credit_t  cc_p_d_i,
    input  dllp_pkg::fc_credit_t  cc_np_h_i,
    input  dllp_pkg::fc_credit_t  cc_cpl_h_i,
    input  dllp_pkg::fc_credit_t  cc_cpl_d_i,
    input  logic                  nak_scheduled_i,
    input  dllp_pkg::seq_num_t    next_rcv_seq_i,
    output logic                  body_valid_o,
    output dllp_pkg::dllp_body_t  body_o,
    input  logic                  body_accept_i
);

    localparam int CNT_W = $clog2(RESEND_INTERVAL + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESEND_INTERVAL - 1);

    typedef enum logic [2:0] {S_IDLE, S_P, S_NP, S_CPL, S_AN, S_WAIT} state_e;

    state_e               state_q;
    logic [CNT_W-1:0]     cnt_q;
    logic                 sample;

    dllp_pkg::fc_credit_t p_h_q;
    dllp_pkg::fc_credit_t p_d_q;
    dllp_pkg::fc_credit_t np_h_q;
    dllp_pkg::fc_credit_t cpl_h_q;
    dllp_pkg::fc_credit_t cpl_d_q;
    logic                 nak_q;
    dllp_pkg::seq_num_t   seq_q;

    // A new round starts out of idle or at the end of the wait
    assign sample = (state_q == S_IDLE) || (state_q == S_WAIT && cnt_q == CNT_LAST);

    always_ff @(posedge sclk) begin
        if (rst_i || link_state_i != dllp_pkg::LINK_ACTIVE) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: state_q <= S_P;
                S_P:    if (body_accept_i) state_q <= S_NP;
                S_NP:   if (body_accept_i) state_q <= S_CPL;
                S_CPL:  if (body_accept_i) state_q <= S_AN;
                S_AN: begin
                    if (body_accept_i) begin
                        state_q <= S_WAIT;
                        cnt_q   <= '0;
                    end
                end
                S_WAIT: begin
                    if (cnt_q == CNT_LAST)
                        state_q <= S_P;
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Snapshot held for the whole round
    always_ff @(posedge sclk) begin
        if (sample) begin
            p_h_q   <= cc_p_h_i;
            p_d_q   <= cc_p_d_i;
            np_h_q  <= cc_np_h_i;
            cpl_h_q <= cc_cpl_h_i;
            cpl_d_q <= cc_cpl_d_i;
            nak_q   <= nak_scheduled_i;
            seq_q   <= next_rcv_seq_i;
        end
    end

    always_comb begin
        case (state_q)
            S_NP:    body_o = dllp_pkg::fc_body(dllp_pkg::DLLP_UPDATEFC_NP, np_h_q, '0);
            S_CPL:   body_o = dllp_pkg::fc_body(dllp_pkg::DLLP_UPDATEFC_CPL, cpl_h_q, cpl_d_q);
            S_AN:    body_o = dllp_pkg::acknak_body(
                         nak_q ? dllp_pkg::DLLP_NAK : dllp_pkg::DLLP_ACK, seq_q);
            default: body_o = dllp_pkg::fc_body(dllp_pkg::DLLP_UPDATEFC_P, p_h_q, p_d_q);
        endcase
    end

    assign body_valid_o = (state_q == S_P) || (state_q == S_NP) ||
                          (state_q == S_CPL) || (state_q == S_AN);

endmodule

/* hdl/dllp_framer.sv */
`timescale 1ns/1ps

module dllp_framer #(
    parameter int PIPE_DATA_WIDTH = 256
) (
    input  logic                       sclk,
    input  logic                       rst_i,
    input  logic                       in_valid_i,
    input  dllp_pkg::dllp_body_t       in_body_i,
    output logic                       in_ready_o,
    output logic                       dllp_valid_o,
    output logic [PIPE_DATA_WIDTH-1:0] dllp_data_o,
    input  logic                       dllp_ready_i
);

    logic                       valid_q;
    logic [PIPE_DATA_WIDTH-1:0] data_q;
    logic [PIPE_DATA_WIDTH-1:0] next_word;

    // Token in the low bits, then body and CRC, rest zero
    always_comb begin
        next_word       = '0;
        next_word[63:0] = {dllp_pkg::dllp_crc16(in_body_i), in_body_i, dllp_pkg::DLLP_SDP_TOKEN};
    end

    // Free slot, or the held word leaves this cycle
    assign in_ready_o = !valid_q || dllp_ready_i;

    always_ff @(posedge sclk) begin
        if (rst_i)
            valid_q <= 1'b0;
        else if (in_valid_i && in_ready_o)
            valid_q <= 1'b1;
        else if (dllp_ready_i)
            valid_q <= 1'b0;
    end

    always_ff @(posedge sclk) begin
        if (in_valid_i && in_ready_o)
            data_q <= next_word;
    end

    assign dllp_valid_o = valid_q;
    assign dllp_data_o  = data_q;

    a_out_hold: assert property (@(posedge sclk) disable iff (rst_i)
        dllp_valid_o && !dllp_ready_i |=> dllp_valid_o && $stable(dllp_data_o));

endmodule

/* hdl/dllp_generator_top.sv */
`timescale 1ns/1ps

module dllp_generator_top #(
    parameter int PIPE_DATA_WIDTH         = 256,
    parameter int RESEND_INTERVAL         = 1024,
    parameter int CREDIT_LIMIT_P_HEADER   = 16,
    parameter int CREDIT_LIMIT_P_DATA     = 16,
    parameter int CREDIT_LIMIT_NP_HEADER  = 16,
    parameter int CREDIT_LIMIT_CPL_HEADER = 16,
    parameter int CREDIT_LIMIT_CPL_DATA   = 16
) (
    input  logic                       sclk,
    input  logic                       rst_i,
    input  dllp_pkg::link_state_e      link_state_i,
    input  dllp_pkg::fc_credit_t       cc_p_h_i,
    input  dllp_pkg::fc_credit_t       cc_p_d_i,
    input  dllp_pkg::fc_credit_t       cc_np_h_i,
    input  dllp_pkg::fc_credit_t       cc_cpl_h_i,
    input  dllp_pkg::fc_credit_t       cc_cpl_d_i,
    input  logic                       nak_scheduled_i,
    input  dllp_pkg::seq_num_t         next_rcv_seq_i,
    output logic [PIPE_DATA_WIDTH-1:0] dllp_data_o,
    output logic                       dllp_valid_o,
    input  logic                       dllp_ready_i,
    output logic                       init1_done_o,
    output logic                       init2_done_o
);

    logic                 init1_valid;
    logic                 init2_valid;
    logic                 act_valid;
    dllp_pkg::dllp_body_t init1_body;
    dllp_pkg::dllp_body_t init2_body;
    dllp_pkg::dllp_body_t act_body;
    logic [2:0]           peer_accept;  // Peer 0 init1, 1 init2, 2 active
    logic                 arb_valid;
    dllp_pkg::dllp_body_t arb_body;
    logic                 framer_ready;

    fc_init_sequencer #(
        .PHASE                   (dllp_pkg::LINK_INIT1),
        .RESEND_INTERVAL         (RESEND_INTERVAL),
        .CREDIT_LIMIT_P_HEADER   (CREDIT_LIMIT_P_HEADER),
        .CREDIT_LIMIT_P_DATA     (CREDIT_LIMIT_P_DATA),
        .CREDIT_LIMIT_NP_HEADER  (CREDIT_LIMIT_NP_HEADER),
        .CREDIT_LIMIT_CPL_HEADER (CREDIT_LIMIT_CPL_HEADER),
        .CREDIT_LIMIT_CPL_DATA   (CREDIT_LIMIT_CPL_DATA)
    ) init1_seq_i (
        .sclk          (sclk),
        .rst_i         (rst_i),
        .link_state_i  (link_state_i),
        .body_valid_o  (init1_valid),
        .body_o        (init1_body),
        .body_accept_i (peer_accept[0]),
        .init_done_o   (init1_done_o)
    );

    fc_init_sequencer #(
        .PHASE                   (dllp_pkg::LINK_INIT2),
        .RESEND_INTERVAL         (RESEND_INTERVAL),
        .CREDIT_LIMIT_P_HEADER   (CREDIT_LIMIT_P_HEADER),
        .CREDIT_LIMIT_P_DATA     (CREDIT_LIMIT_P_DATA),
        .CREDIT_LIMIT_NP_HEADER  (CREDIT_LIMIT_NP_HEADER),
        .CREDIT_LIMIT_CPL_HEADER (CREDIT_LIMIT_CPL_HEADER),
        .CREDIT_LIMIT_CPL_DATA   (CREDIT_LIMIT_CPL_DATA)
    ) init2_seq_i (
        .sclk          (sclk),
        .rst_i         (rst_i),
        .link_state_i  (link_state_i),
        .body_valid_o  (init2_valid),
        .body_o        (init2_body),
        .body_accept_i (peer_accept[1]),
        .init_done_o   (init2_done_o)
    );

    active_dllp_scheduler #(
        .RESEND_INTERVAL (RESEND_INTERVAL)
    ) active_sched_i (
        .sclk            (sclk),
        .rst_i           (rst_i),
        .link_state_i    (link_state_i),
        .cc_p_h_i        (cc_p_h_i),
        .cc_p_d_i        (cc_p_d_i),
        .cc_np_h_i       (cc_np_h_i),
        .cc_cpl_h_i      (cc_cpl_h_i),
        .cc_cpl_d_i      (cc_cpl_d_i),
        .nak_scheduled_i (nak_scheduled_i),
        .next_rcv_seq_i  (next_rcv_seq_i),
        .body_valid_o    (act_valid),
        .body_o          (act_body),
        .body_accept_i   (peer_accept[2])
    );

    dllp_tx_arbiter #(
        .NUM_PEERS (3)
    ) arbiter_i (
        .sclk         (sclk),
        .rst_i        (rst_i),
        .req_valid_i  ({act_valid, init2_valid, init1_valid}),
        .req_body_i   ({act_body, init2_body, init1_body}),
        .req_accept_o (peer_accept),
        .out_valid_o  (arb_valid),
        .out_body_o   (arb_body),
        .out_ready_i  (framer_ready)
    );

    dllp_framer #(
        .PIPE_DATA_WIDTH (PIPE_DATA_WIDTH)
    ) framer_i (
        .sclk         (sclk),
        .rst_i        (rst_i),
        .in_valid_i   (arb_valid),
        .in_body_i    (arb_body),
        .in_ready_o   (framer_ready),
        .dllp_valid_o (dllp_valid_o),
        .dllp_data_o  (dllp_data_o),
        .dllp_ready_i (dllp_ready_i)
    );

endmodule

/* hdl/dllp_pkg.sv */
package dllp_pkg;

    // Link state as reported by the DLCMSM
    typedef enum logic [1:0] {
        LINK_INACTIVE = 2'd0,
        LINK_INIT1    = 2'd1,
        LINK_INIT2    = 2'd2,
        LINK_ACTIVE   = 2'd3
    } link_state_e;

    typedef logic [31:0] dllp_body_t;
    typedef logic [15:0] crc16_t;
    typedef logic [11:0] fc_credit_t;
    typedef logic [11:0] seq_num_t;
    typedef logic [7:0]  dllp_type_t;

    localparam dllp_type_t DLLP_INITFC1_P    = 8'h40;
    localparam dllp_type_t DLLP_INITFC1_NP   = 8'h50;
    localparam dllp_type_t DLLP_INITFC1_CPL  = 8'h60;
    localparam dllp_type_t DLLP_INITFC2_P    = 8'hC0;
    localparam dllp_type_t DLLP_INITFC2_NP   = 8'hD0;
    localparam dllp_type_t DLLP_INITFC2_CPL  = 8'hE0;
    localparam dllp_type_t DLLP_UPDATEFC_P   = 8'h80;
    localparam dllp_type_t DLLP_UPDATEFC_NP  = 8'h90;
    localparam dllp_type_t DLLP_UPDATEFC_CPL = 8'hA0;
    localparam dllp_type_t DLLP_ACK          = 8'h00;
    localparam dllp_type_t DLLP_NAK          = 8'h10;

    localparam logic [15:0] DLLP_SDP_TOKEN = 16'hACF0;
    localparam crc16_t      CRC16_POLY     = 16'h100B;
    localparam crc16_t      CRC16_INIT     = 16'hFFFF;

    // Bitwise CRC-16, MSB of the body first
    function automatic crc16_t dllp_crc16(dllp_body_t body);
        crc16_t crc;
        crc = CRC16_INIT;
        for (int i = 31; i >= 0; i--) begin
            if (crc[15] ^ body[i])
                crc = {crc[14:0], 1'b0} ^ CRC16_POLY;
            else
                crc = {crc[14:0], 1'b0};
        end
        return ~crc;
    endfunction

    function automatic dllp_body_t fc_body(dllp_type_t dtype, fc_credit_t hdr, fc_credit_t data);
        return {dtype, 2'b00, hdr[7:0], 2'b00, data};  // Scale fields stay zero
    endfunction

    function automatic dllp_body_t acknak_body(dllp_type_t dtype, seq_num_t seq);
        return {dtype, 12'd0, seq};
    endfunction

endpackage

/* hdl/dllp_tx_arbiter.sv */
`timescale 1ns/1ps

module dllp_tx_arbiter #(
    parameter int NUM_PEERS = 3
) (
    input  logic                            sclk,
    input  logic                            rst_i,
    input  logic [NUM_PEERS-1:0]            req_valid_i,
    input  logic [NUM_PEERS*32-1:0]         req_body_i,
    output logic [NUM_PEERS-1:0]            req_accept_o,
    output logic                            out_valid_o,
    output dllp_pkg::dllp_body_t            out_body_o,
    input  logic                            out_ready_i
);

    localparam int IDX_W  = (NUM_PEERS > 1) ? $clog2(NUM_PEERS) : 1;
    localparam int BODY_W = $bits(dllp_pkg::dllp_body_t);

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] lock_idx_q;
    logic [IDX_W-1:0] search_idx;
    logic [IDX_W-1:0] grant_idx;
    logic             lock_q;

    // Walk backwards so the nearest peer after the last winner is kept
    always_comb begin
        int cand;
        search_idx = last_q;
        for (int i = NUM_PEERS; i >= 1; i--) begin
            cand = (int'(last_q) + i) % NUM_PEERS;
            if (req_valid_i[cand])
                search_idx = IDX_W'(cand);
        end
    end

    assign grant_idx   = lock_q ? lock_idx_q : search_idx;  // Hold the grant while stalled
    assign out_valid_o = req_valid_i[grant_idx];
    assign out_body_o  = req_body_i[int'(grant_idx)*BODY_W +: BODY_W];

    always_comb begin
        req_accept_o            = '0;
        req_accept_o[grant_idx] = out_valid_o && out_ready_i;
    end

    always_ff @(posedge sclk) begin
        if (rst_i) begin
            last_q     <= IDX_W'(NUM_PEERS - 1);  // Peer 0 goes first
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= out_valid_o && !out_ready_i;
            lock_idx_q <= grant_idx;
            if (out_valid_o && out_ready_i)
                last_q <= grant_idx;
        end
    end

    // A stalled offer keeps its body until it is taken or withdrawn
    a_grant_hold: assert property (@(posedge sclk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> !out_valid_o || $stable(out_body_o));

endmodule

/* hdl/fc_init_sequencer.sv */
`timescale 1ns/1ps

module fc_init_sequencer #(
    parameter dllp_pkg::link_state_e PHASE = dllp_pkg::LINK_INIT1,
    parameter int RESEND_INTERVAL         = 1024,
    parameter int CREDIT_LIMIT_P_HEADER   = 16,
    parameter int CREDIT_LIMIT_P_DATA     = 16,
    parameter int CREDIT_LIMIT_NP_HEADER  = 16,
    parameter int CREDIT_LIMIT_CPL_HEADER = 16,
    parameter int CREDIT_LIMIT_CPL_DATA   = 16
) (
    input  logic                  sclk,
    input  logic                  rst_i,
    input  dllp_pkg::link_state_e link_state_i,
    output logic                  body_valid_o,
    output dllp_pkg::dllp_body_t  body_o,
    input  logic                  body_accept_i,
    output logic                  init_done_o
);

    localparam int CNT_W = $clog2(RESEND_INTERVAL + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESEND_INTERVAL - 1);
    localparam bit IS_INIT2 = (PHASE == dllp_pkg::LINK_INIT2);

    // Bodies are fixed by the credit limits, so they are constants here
    localparam dllp_pkg::dllp_body_t BODY_P = dllp_pkg::fc_body(
        IS_INIT2 ? dllp_pkg::DLLP_INITFC2_P : dllp_pkg::DLLP_INITFC1_P,
        dllp_pkg::fc_credit_t'(CREDIT_LIMIT_P_HEADER),
        dllp_pkg::fc_credit_t'(CREDIT_LIMIT_P_DATA));
    localparam dllp_pkg::dllp_body_t BODY_NP = dllp_pkg::fc_body(
        IS_INIT2 ? dllp_pkg::DLLP_INITFC2_NP : dllp_pkg::DLLP_INITFC1_NP,
        dllp_pkg::fc_credit_t'(CREDIT_LIMIT_NP_HEADER),
        dllp_pkg::fc_credit_t'(0));
    localparam dllp_pkg::dllp_body_t BODY_CPL = dllp_pkg::fc_body(
        IS_INIT2 ? dllp_pkg::DLLP_INITFC2_CPL : dllp_pkg::DLLP_INITFC1_CPL,
        dllp_pkg::fc_credit_t'(CREDIT_LIMIT_CPL_HEADER),
        dllp_pkg::fc_credit_t'(CREDIT_LIMIT_CPL_DATA));

    typedef enum logic [2:0] {S_IDLE, S_P, S_NP, S_CPL, S_WAIT} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;

    always_ff @(posedge sclk) begin
        if (rst_i || link_state_i != PHASE) begin  // Leaving the phase restarts the FSM
            state_q <= S_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: state_q <= S_P;
                S_P:    if (body_accept_i) state_q <= S_NP;
                S_NP:   if (body_accept_i) state_q <= S_CPL;
                S_CPL: begin
                    if (body_accept_i) begin
                        state_q <= S_WAIT;
                        cnt_q   <= '0;
                        done_q  <= 1'b1;  // First full round flags done
                    end
                end
                S_WAIT: begin
                    if (cnt_q == CNT_LAST)
                        state_q <= S_P;
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            S_NP:    body_o = BODY_NP;
            S_CPL:   body_o = BODY_CPL;
            default: body_o = BODY_P;
        endcase
    end

    assign body_valid_o = (state_q == S_P) || (state_q == S_NP) || (state_q == S_CPL);
    assign init_done_o  = done_q;

    a_body_hold: assert property (@(posedge sclk) disable iff (rst_i)
        body_valid_o && !body_accept_i && link_state_i == PHASE
        |=> body_valid_o && $stable(body_o));

endmodule

/* include/dllp_tb_model.svh */
`ifndef DLLP_TB_MODEL_SVH
`define DLLP_TB_MODEL_SVH

// Low 64 bits of the expected PIPE word, higher bits are zero
function automatic logic [63:0] model_word(dllp_pkg::dllp_body_t body);
    return {dllp_pkg::dllp_crc16(body), body, dllp_pkg::DLLP_SDP_TOKEN};
endfunction

function automatic logic [63:0] model_fc_word(dllp_pkg::dllp_type_t dtype, int hdr, int data);
    return model_word(dllp_pkg::fc_body(dtype, dllp_pkg::fc_credit_t'(hdr),
                                        dllp_pkg::fc_credit_t'(data)));
endfunction

function automatic logic [63:0] model_acknak_word(logic nak, dllp_pkg::seq_num_t seq);
    dllp_pkg::dllp_type_t dtype;
    dtype = nak ? dllp_pkg::DLLP_NAK : dllp_pkg::DLLP_ACK;
    return model_word(dllp_pkg::acknak_body(dtype, seq));
endfunction

// Kind 0 is P, 1 is NP, 2 is CPL
function automatic dllp_pkg::dllp_type_t model_fc_type(dllp_pkg::link_state_e state, int kind);
    dllp_pkg::dllp_type_t base;
    case (state)
        dllp_pkg::LINK_INIT1: base = dllp_pkg::DLLP_INITFC1_P;
        dllp_pkg::LINK_INIT2: base = dllp_pkg::DLLP_INITFC2_P;
        default:              base = dllp_pkg::DLLP_UPDATEFC_P;
    endcase
    return base + dllp_pkg::dllp_type_t'(kind * 16);
endfunction

`endif

/* tb/dllp_generator_tb.sv */
`timescale 1ns/1ps

module dllp_generator_tb;

    localparam int PIPE_W          = 128;
    localparam int RESEND_INTERVAL = 32;
    localparam int LIM_P_H         = 33;
    localparam int LIM_P_D         = 200;
    localparam int LIM_NP_H        = 17;
    localparam int LIM_CPL_H       = 5;
    localparam int LIM_CPL_D       = 300;
    // Longest test spans about three resend rounds, so this leaves wide margin
    localparam int TIMEOUT_CYCLES  = 2000;

    logic                  sclk;
    logic                  rst;
    dllp_pkg::link_state_e link_state;
    dllp_pkg::fc_credit_t  cc_p_h;
    dllp_pkg::fc_credit_t  cc_p_d;
    dllp_pkg::fc_credit_t  cc_np_h;
    dllp_pkg::fc_credit_t  cc_cpl_h;
    dllp_pkg::fc_credit_t  cc_cpl_d;
    logic                  nak_scheduled;
    dllp_pkg::seq_num_t    next_rcv_seq;
    logic                  dllp_ready = 1'b0;
    logic [PIPE_W-1:0]     dllp_data;
    logic                  dllp_valid;
    logic                  init1_done;
    logic                  init2_done;

    logic                  stall_en   = 1'b0;
    logic [31:0]           lcg_state  = 32'h3f5b186f;
    int                    cycle_cnt  = 0;
    int                    errors     = 0;
    int                    checks     = 0;
    int                    tests_run  = 0;
    int                    mon_errors = 0;
    int                    stall_seen = 0;
    logic                  hold_q     = 1'b0;
    logic [PIPE_W-1:0]     held_data;

    `include "dllp_tb_model.svh"

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (5)
    ) clk_gen_i (
        .sclk_o (sclk),
        .rst_o  (rst)
    );

    dllp_generator_top #(
        .PIPE_DATA_WIDTH         (PIPE_W),
        .RESEND_INTERVAL         (RESEND_INTERVAL),
        .CREDIT_LIMIT_P_HEADER   (LIM_P_H),
        .CREDIT_LIMIT_P_DATA     (LIM_P_D),
        .CREDIT_LIMIT_NP_HEADER  (LIM_NP_H),
        .CREDIT_LIMIT_CPL_HEADER (LIM_CPL_H),
        .CREDIT_LIMIT_CPL_DATA   (LIM_CPL_D)
    ) dut_i (
        .sclk            (sclk),
        .rst_i           (rst),
        .link_state_i    (link_state),
        .cc_p_h_i        (cc_p_h),
        .cc_p_d_i        (cc_p_d),
        .cc_np_h_i       (cc_np_h),
        .cc_cpl_h_i      (cc_cpl_h),
        .cc_cpl_d_i      (cc_cpl_d),
        .nak_scheduled_i (nak_scheduled),
        .next_rcv_seq_i  (next_rcv_seq),
        .dllp_data_o     (dllp_data),
        .dllp_valid_o    (dllp_valid),
        .dllp_ready_i    (dllp_ready),
        .init1_done_o    (init1_done),
        .init2_done_o    (init2_done)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge sclk) begin
        lcg_state <= lcg_next(lcg_state);
        if (stall_en)
            dllp_ready <= lcg_state[31];  // About half the cycles stall
        else
            dllp_ready <= 1'b1;
    end

    always @(posedge sclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, an expected DLLP or flag never arrived", cycle_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    // A stalled word must stay put until it is taken
    always @(negedge sclk) begin
        if (rst) begin
            hold_q = 1'b0;
        end else begin
            if (hold_q) begin
                assert (dllp_valid === 1'b1) else begin
                    $display("dllp_valid_o dropped while a word was stalled");
                    mon_errors++;
                end
                assert (dllp_data === held_data) else begin
                    $display("[ERROR] dllp_data_o changed under stall: got %h, held %h",
                             dllp_data, held_data);
                    mon_errors++;
                end
            end
            hold_q    = dllp_valid && !dllp_ready;
            held_data = dllp_data;
            if (hold_q)
                stall_seen++;
        end
    end

    function automatic logic [63:0] expected_init(dllp_pkg::link_state_e phase, int kind);
        dllp_pkg::dllp_type_t t;
        t = model_fc_type(phase, kind);
        case (kind)
            0:       return model_fc_word(t, LIM_P_H, LIM_P_D);
            1:       return model_fc_word(t, LIM_NP_H, 0);
            default: return model_fc_word(t, LIM_CPL_H, LIM_CPL_D);
        endcase
    endfunction

    task automatic compare_word(input string label, input logic [PIPE_W-1:0] got,
                                input logic [63:0] exp64);
        logic [PIPE_W-1:0] exp;
        exp = {{(PIPE_W-64){1'b0}}, exp64};
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] dllp_data_o %s: got %h, expected %h", label, got, exp);
            errors++;
        end
    endtask

    task automatic expect_level(input string name, input logic val, input logic exp);
        checks++;
        assert (val === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, val, exp);
            errors++;
        end
    endtask

    // Returns the word of the next output handshake
    task automatic get_word(output logic [PIPE_W-1:0] word);
        @(negedge sclk);
        while (!(dllp_valid && dllp_ready))
            @(negedge sclk);
        word = dllp_data;
    endtask

    task automatic wait_done(input dllp_pkg::link_state_e phase);
        int   n;
        logic flag;
        n    = 0;
        flag = (phase == dllp_pkg::LINK_INIT1) ? init1_done : init2_done;
        while (!flag && n < 4) begin
            @(negedge sclk);
            n++;
            flag = (phase == dllp_pkg::LINK_INIT1) ? init1_done : init2_done;
        end
        checks++;
        assert (flag === 1'b1) else begin
            $display("%s done flag did not rise after the first CPL word", phase.name());
            errors++;
        end
    endtask

    task automatic go_inactive();
        @(posedge sclk);
        link_state <= dllp_pkg::LINK_INACTIVE;
        stall_en   <= 1'b0;
        repeat (6) @(posedge sclk);  // Let any framed word drain
    endtask

    task automatic drive_active_inputs(input logic [11:0] ph, input logic [11:0] pd,
                                       input logic [11:0] nph, input logic [11:0] cplh,
                                       input logic [11:0] cpld, input logic nak,
                                       input logic [11:0] seq);
        cc_p_h        <= ph;
        cc_p_d        <= pd;
        cc_np_h       <= nph;
        cc_cpl_h      <= cplh;
        cc_cpl_d      <= cpld;
        nak_scheduled <= nak;
        next_rcv_seq  <= seq;
    endtask

    task automatic report_test(input string name, input int err_before);
        int now;
        now = errors + mon_errors;
        tests_run++;
        $display("%s: %s, %0d errors", name, (now == err_before) ? "passed" : "failed",
                 now - err_before);
    endtask

    task automatic test_inactive();
        int e0;
        e0 = errors + mon_errors;
        repeat (20) begin
            @(negedge sclk);
            expect_level("dllp_valid_o", dllp_valid, 1'b0);
            expect_level("init1_done_o", init1_done, 1'b0);
            expect_level("init2_done_o", init2_done, 1'b0);
        end
        report_test("inactive link", e0);
    endtask

    task automatic test_init_phase(input dllp_pkg::link_state_e phase, input string name);
        int                e0;
        logic [PIPE_W-1:0] w;
        e0 = errors + mon_errors;
        go_inactive();
        @(posedge sclk);
        link_state <= phase;
        for (int k = 0; k < 3; k++) begin
            get_word(w);
            compare_word($sformatf("%s word %0d", name, k), w, expected_init(phase, k));
        end
        wait_done(phase);
        if (phase == dllp_pkg::LINK_INIT1)
            expect_level("init2_done_o", init2_done, 1'b0);
        else
            expect_level("init1_done_o", init1_done, 1'b0);
        report_test(name, e0);
    endtask

    task automatic test_init1_stalls();
        int                e0;
        int                s0;
        logic [PIPE_W-1:0] w;
        e0 = errors + mon_errors;
        go_inactive();
        s0 = stall_seen;
        @(posedge sclk);
        link_state <= dllp_pkg::LINK_INIT1;
        stall_en   <= 1'b1;
        for (int k = 0; k < 6; k++) begin
            get_word(w);
            compare_word($sformatf("stalled round %0d word %0d", k / 3, k % 3), w,
                         expected_init(dllp_pkg::LINK_INIT1, k % 3));
        end
        checks++;
        assert (stall_seen > s0) else begin
            $display("No stalled cycle was seen while dllp_valid_o was high");
            errors++;
        end
        report_test("init1 with stalls", e0);
    endtask

    task automatic check_active_round(input string name, input logic [11:0] ph,
                                      input logic [11:0] pd, input logic [11:0] nph,
                                      input logic [11:0] cplh, input logic [11:0] cpld,
                                      input logic nak, input logic [11:0] seq);
        logic [PIPE_W-1:0] w;
        get_word(w);
        compare_word({name, " UpdateFC P"}, w,
                     model_fc_word(model_fc_type(dllp_pkg::LINK_ACTIVE, 0), int'(ph), int'(pd)));
        get_word(w);
        compare_word({name, " UpdateFC NP"}, w,
                     model_fc_word(model_fc_type(dllp_pkg::LINK_ACTIVE, 1), int'(nph), 0));
        get_word(w);
        compare_word({name, " UpdateFC CPL"}, w,
                     model_fc_word(model_fc_type(dllp_pkg::LINK_ACTIVE, 2), int'(cplh),
                                   int'(cpld)));
        get_word(w);
        compare_word({name, " Ack/Nak"}, w, model_acknak_word(nak, seq));
    endtask

    task automatic test_active_rounds();
        int e0;
        e0 = errors + mon_errors;
        go_inactive();
        @(posedge sclk);
        drive_active_inputs(12'h1A3, 12'h0C8, 12'h011, 12'h07F, 12'h2F0, 1'b0, 12'h5A5);
        link_state <= dllp_pkg::LINK_ACTIVE;
        check_active_round("ack round", 12'h1A3, 12'h0C8, 12'h011, 12'h07F, 12'h2F0,
                           1'b0, 12'h5A5);
        @(posedge sclk);
        drive_active_inputs(12'h044, 12'h123, 12'h0EE, 12'h0B2, 12'h0FF, 1'b1, 12'h5A9);
        check_active_round("nak round", 12'h044, 12'h123, 12'h0EE, 12'h0B2, 12'h0FF,
                           1'b1, 12'h5A9);
        report_test("active rounds", e0);
    endtask

    initial begin
        link_state    = dllp_pkg::LINK_INACTIVE;
        cc_p_h        = '0;
        cc_p_d        = '0;
        cc_np_h       = '0;
        cc_cpl_h      = '0;
        cc_cpl_d      = '0;
        nak_scheduled = 1'b0;
        next_rcv_seq  = '0;
        wait (rst === 1'b0);
        @(posedge sclk);
        test_inactive();
        test_init_phase(dllp_pkg::LINK_INIT1, "init1 words");
        test_init1_stalls();
        test_init_phase(dllp_pkg::LINK_INIT2, "init2 words");
        test_active_rounds();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks,
                 errors + mon_errors);
        if (errors + mon_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic sclk_o,
    output logic rst_o
);

    initial begin
        sclk_o = 1'b0;
        forever #(PERIOD_NS / 2) sclk_o = ~sclk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge sclk_o);
        rst_o <= 1'b0;  // Released on a rising edge like any other input
    end

endmodule
